/* src.f */
+incdir+testbench
common/lsq_pkg.sv
store_queue/store_queue.sv
store_queue/store_forward.sv
load_buffer/load_buffer.sv
source/load_store_queue.sv
testbench/lsq_tb.sv

/* run_sim.sh */
#!/bin/sh
# build the load/store queue testbench with verilator and run it
# exit status is zero only when the pass line is printed

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --assert -Wno-fatal --top-module lsq_tb -f src.f -o lsq_sim; then
    echo "verilator build failed"
    exit 1
fi

sim_output=$(./obj_dir/lsq_sim 2>&1)
sim_status=$?
printf '%s\n' "$sim_output"

if [ "$sim_status" -ne 0 ]; then
    echo "simulation exited with status $sim_status"
    exit 1
fi

if printf '%s\n' "$sim_output" | grep -qxF '** PASS **'; then
    exit 0
fi

echo "pass line not found in simulation output"
exit 1

/* testbench/lsq_tb_table.svh */
    localparam int row_count = 21;

    // stimulus: sq_alloc sq_res sq_idx sq_base sq_off sq_data sq_size sq_retire
    //           lb_alloc lb_res lb_idx lb_base lb_off lb_size lb_signed
    // expected: sq_full lb_full sc_addr sc_data sc_size fwd_valid fwd_value lc_valid lc_addr
    //           sq_tail head_resolved alloc_idx load_row
    row_t table_rows [row_count] = '{
        // lone load, no older stores, goes to the cache
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 1, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 0, 0, 0, 0},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 0, 1, 0, 'h200, 'h10, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 0, 0, 0, 0},
        '{1, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 0, 0, 0, 0},
        // fill both queues, loads sit behind unresolved S0
        '{1, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 1, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 1, 'h210, 1, 0, 0, 1},
        '{1, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 1, 1, 0, 'h100, 'h3, sz_b, 1,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 2, 0, 1, 0},
        '{1, 1, 1, 'h100, 'h40, 'hcafef00d, sz_w, 0, 1, 1, 1, 'h100, 'h40, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 3, 0, 2, 0},
        '{1, 1, 2, 'h180, 'h0, 'hbeef8001, sz_w, 0, 1, 1, 2, 'h180, 'h2, sz_h, 0,
          0, 0, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 4, 0, 3, 0},
        // S3 hits the same word as S1 but is younger
        '{1, 1, 3, 'h140, 'h0, 'h12345678, sz_w, 0, 0, 1, 3, 'h140, 'h0, sz_w, 0,
          0, 1, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 5, 0, 0, 0},
        '{1, 1, 4, 'h2f0, 'h10, 'h55667788, sz_w, 0, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 1, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 6, 0, 0, 0},
        '{1, 1, 5, 'h400, 'h0, 'ha5, sz_b, 0, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 1, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 7, 0, 0, 0},
        // S0 resolves last, all four loads unblock
        '{0, 1, 0, 'h100, 'h0, 'h81234567, sz_w, 0, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          1, 1, 'h0, 'h0, sz_w, 0, 'h0, 0, 'h0, 0, 0, 0, 0},
        '{0, 1, 6, 'h404, 'h0, 'h1234, sz_h, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          1, 1, 'h100, 'h81234567, sz_w, 0, 'h0, 0, 'h0, 0, 1, 0, 0},
        '{0, 1, 7, 'h408, 'h0, 'h0badf00d, sz_w, 0, 1, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 1, 'hffffff81, 0, 'h0, 0, 1, 0, 4},
        // L5 straddles S4 and must wait for it
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 0, 0, 1, 0, 'h300, 'h2, sz_w, 0,
          0, 0, 'h0, 'h0, sz_w, 1, 'hcafef00d, 0, 'h0, 0, 1, 0, 5},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h140, 'hcafef00d, sz_w, 1, 'h0000beef, 0, 'h0, 0, 1, 0, 6},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h180, 'hbeef8001, sz_w, 1, 'h12345678, 0, 'h0, 0, 1, 0, 7},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h140, 'h12345678, sz_w, 0, 'h0, 0, 'h0, 0, 1, 0, 0},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h300, 'h55667788, sz_w, 0, 'h0, 0, 'h0, 0, 1, 0, 0},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h400, 'ha5, sz_b, 0, 'h0, 0, 'h0, 0, 1, 0, 0},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h404, 'h1234, sz_h, 0, 'h0, 1, 'h302, 0, 1, 0, 13},
        '{0, 0, 0, 'h0, 'h0, 'h0, sz_w, 1, 0, 0, 0, 'h0, 'h0, sz_w, 0,
          0, 0, 'h408, 'h0badf00d, sz_w, 0, 'h0, 0, 'h0, 0, 1, 0, 0}
    };

/* testbench/lsq_tb.sv */
`timescale 1ns/10ps

module lsq_tb
    import lsq_pkg::*;
();

    // one table row per clock cycle
    typedef struct packed {
        // store side stimulus
        logic       sq_alloc;
        logic       sq_res;
        sq_idx_t    sq_idx;
        word_t      sq_base;
        word_t      sq_off;
        word_t      sq_data;
        mem_size_e  sq_size;
        logic       sq_retire;
        // load side stimulus
        logic       lb_alloc;
        logic       lb_res;
        lb_idx_t    lb_idx;
        word_t      lb_base;
        word_t      lb_off;
        mem_size_e  lb_size;
        logic       lb_signed;
        // expected outputs
        logic       x_sq_full;
        logic       x_lb_full;
        word_t      x_sc_addr;
        word_t      x_sc_data;
        mem_size_e  x_sc_size;
        logic       x_fwd_valid;
        word_t      x_fwd_value;
        logic       x_lc_valid;
        word_t      x_lc_addr;
        sq_idx_t    x_sq_tail;
        logic       x_head_res;
        lb_idx_t    x_alloc_idx;
        // row whose resolve fed the load finishing now
        logic [7:0] x_load_row;
    } row_t;

    // short size names for the table
    localparam mem_size_e sz_b = byte_access;
    localparam mem_size_e sz_h = half_access;
    localparam mem_size_e sz_w = word_access;

    `include "lsq_tb_table.svh"

    // two cycles per row plus reset slack
    localparam int cycle_limit = 2 * row_count + 20;

    logic      clock;
    logic      reset;
    logic      sq_alloc;
    logic      sq_resolve_valid;
    sq_idx_t   sq_resolve_idx;
    word_t     sq_base;
    word_t     sq_offset;
    word_t     sq_data;
    mem_size_e sq_size;
    rob_idx_t  sq_rob_idx;
    logic      sq_retire;
    logic      sq_full;
    logic      sq_head_resolved;
    sq_idx_t   sq_tail;
    logic      store_cache_valid;
    word_t     store_cache_addr;
    word_t     store_cache_data;
    mem_size_e store_cache_size;
    logic      lb_alloc;
    logic      lb_resolve_valid;
    lb_idx_t   lb_resolve_idx;
    word_t     lb_base;
    word_t     lb_offset;
    mem_size_e lb_size;
    logic      lb_signed;
    prf_idx_t  lb_dest_preg;
    rob_idx_t  lb_rob_idx;
    logic      lb_full;
    lb_idx_t   lb_alloc_idx;
    logic      forward_valid;
    word_t     forward_value;
    prf_idx_t  forward_dest_preg;
    rob_idx_t  forward_rob_idx;
    logic      load_cache_valid;
    word_t     load_cache_addr;
    mem_size_e load_cache_size;
    logic      load_cache_signed;
    prf_idx_t  load_cache_dest_preg;
    rob_idx_t  load_cache_rob_idx;

    int cycle_count = 0;

    load_store_queue dut (.*);

    always #50 clock = ~clock;

    //////////////////////////////////////////////////////////////////////
    // helpers
    //////////////////////////////////////////////////////////////////////

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("** FAIL **");
        $fatal(1, "testbench stopped");
    endtask

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        assert (actual === expected)
            else abort_run($sformatf("error %s expected 0x%08h actual 0x%08h",
                                     name, expected, actual));
    endtask

    task automatic apply_row(input row_t row, input int r);
        sq_alloc         = row.sq_alloc;
        sq_resolve_valid = row.sq_res;
        sq_resolve_idx   = row.sq_idx;
        sq_base          = row.sq_base;
        sq_offset        = row.sq_off;
        sq_data          = row.sq_data;
        sq_size          = row.sq_size;
        // rob tag follows the slot, unique while live
        sq_rob_idx       = rob_idx_t'(row.sq_idx);
        sq_retire        = row.sq_retire;
        lb_alloc         = row.lb_alloc;
        lb_resolve_valid = row.lb_res;
        lb_resolve_idx   = row.lb_idx;
        lb_base          = row.lb_base;
        lb_offset        = row.lb_off;
        lb_size          = row.lb_size;
        lb_signed        = row.lb_signed;
        // load tags carry the row number of the resolve
        lb_dest_preg     = prf_idx_t'(r);
        lb_rob_idx       = rob_idx_t'(r);
    endtask

    task automatic check_row(input row_t row);
        row_t src;
        // stimulus of the load finishing this cycle
        src = table_rows[row.x_load_row];
        check_word("sq_full", word_t'(row.x_sq_full), word_t'(sq_full));
        check_word("sq_tail", word_t'(row.x_sq_tail), word_t'(sq_tail));
        check_word("sq_head_resolved", word_t'(row.x_head_res), word_t'(sq_head_resolved));
        check_word("lb_full", word_t'(row.x_lb_full), word_t'(lb_full));
        if (row.lb_alloc) begin
            check_word("lb_alloc_idx", word_t'(row.x_alloc_idx), word_t'(lb_alloc_idx));
        end
        // head store leaves in its retire cycle
        check_word("store_cache_valid", word_t'(row.sq_retire), word_t'(store_cache_valid));
        if (row.sq_retire) begin
            check_word("store_cache_addr", row.x_sc_addr, store_cache_addr);
            check_word("store_cache_data", row.x_sc_data, store_cache_data);
            check_word("store_cache_size", word_t'(row.x_sc_size), word_t'(store_cache_size));
        end
        check_word("forward_valid", word_t'(row.x_fwd_valid), word_t'(forward_valid));
        if (row.x_fwd_valid) begin
            check_word("forward_value", row.x_fwd_value, forward_value);
            check_word("forward_dest_preg", word_t'(prf_idx_t'(row.x_load_row)),
                       word_t'(forward_dest_preg));
            check_word("forward_rob_idx", word_t'(rob_idx_t'(row.x_load_row)),
                       word_t'(forward_rob_idx));
        end
        check_word("load_cache_valid", word_t'(row.x_lc_valid), word_t'(load_cache_valid));
        if (row.x_lc_valid) begin
            check_word("load_cache_addr", row.x_lc_addr, load_cache_addr);
            check_word("load_cache_size", word_t'(src.lb_size), word_t'(load_cache_size));
            check_word("load_cache_signed", word_t'(src.lb_signed),
                       word_t'(load_cache_signed));
            check_word("load_cache_dest_preg", word_t'(prf_idx_t'(row.x_load_row)),
                       word_t'(load_cache_dest_preg));
            check_word("load_cache_rob_idx", word_t'(rob_idx_t'(row.x_load_row)),
                       word_t'(load_cache_rob_idx));
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // run
    //////////////////////////////////////////////////////////////////////

    always @(posedge clock) begin
        cycle_count <= cycle_count + 1;
        assert (cycle_count < cycle_limit)
            else abort_run($sformatf("run went past %0d cycles without finishing", cycle_limit));
    end

    initial begin
        clock = 1'b0;
        reset = 1'b1;
        apply_row('0, 0);
        repeat (2) @(posedge clock);
        #5;
        reset = 1'b0;
        for (int r = 0; r < row_count; r++) begin
            apply_row(table_rows[r], r);
            // sample just before the next rising edge
            #90;
            check_row(table_rows[r]);
            @(posedge clock);
            #5;
        end
        $display("** PASS **");
        $finish;
    end

endmodule

/* source/load_store_queue.sv */
`timescale 1ns/10ps

module load_store_queue import lsq_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // store side
    input  logic      sq_alloc,
    input  logic      sq_resolve_valid,
    input  sq_idx_t   sq_resolve_idx,
    input  word_t     sq_base,
    input  word_t     sq_offset,
    input  word_t     sq_data,
    input  mem_size_e sq_size,
    input  rob_idx_t  sq_rob_idx,
    input  logic      sq_retire,
    output logic      sq_full,
    output logic      sq_head_resolved,
    output sq_idx_t   sq_tail,
    output logic      store_cache_valid,
    output word_t     store_cache_addr,
    output word_t     store_cache_data,
    output mem_size_e store_cache_size,
    // load side
    input  logic      lb_alloc,
    input  logic      lb_resolve_valid,
    input  lb_idx_t   lb_resolve_idx,
    input  word_t     lb_base,
    input  word_t     lb_offset,
    input  mem_size_e lb_size,
    input  logic      lb_signed,
    input  prf_idx_t  lb_dest_preg,
    input  rob_idx_t  lb_rob_idx,
    output logic      lb_full,
    output lb_idx_t   lb_alloc_idx,
    // load results
    output logic      forward_valid,
    output word_t     forward_value,
    output prf_idx_t  forward_dest_preg,
    output rob_idx_t  forward_rob_idx,
    output logic      load_cache_valid,
    output word_t     load_cache_addr,
    output mem_size_e load_cache_size,
    output logic      load_cache_signed,
    output prf_idx_t  load_cache_dest_preg,
    output rob_idx_t  load_cache_rob_idx
);

    // store queue view shared by both load blocks
    sq_idx_t                sq_head;
    sq_count_t              sq_count;
    word_t                  entry_addr [sq_capacity];
    word_t                  entry_data [sq_capacity];
    mem_size_e              entry_size [sq_capacity];
    logic [sq_capacity-1:0] entry_resolved;

    // load buffer to forward stage
    logic      issue_valid;
    word_t     issue_addr;
    mem_size_e issue_size;
    logic      issue_signed;
    prf_idx_t  issue_dest_preg;
    rob_idx_t  issue_rob_idx;
    sq_count_t issue_older_count;

    store_queue u_store_queue (.*);

    load_buffer u_load_buffer (.*);

    store_forward u_store_forward (.*);

endmodule

/* load_buffer/load_buffer.sv */
`timescale 1ns/10ps

module load_buffer import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    input  logic                   lb_alloc,
    // resolution from the rs
    input  logic                   lb_resolve_valid,
    input  lb_idx_t                lb_resolve_idx,
    input  word_t                  lb_base,
    input  word_t                  lb_offset,
    input  mem_size_e              lb_size,
    input  logic                   lb_signed,
    input  prf_idx_t               lb_dest_preg,
    input  rob_idx_t               lb_rob_idx,
    // store queue side
    input  logic                   sq_retire,
    input  sq_idx_t                sq_head,
    input  sq_count_t              sq_count,
    input  word_t                  entry_addr [sq_capacity],
    input  mem_size_e              entry_size [sq_capacity],
    input  logic [sq_capacity-1:0] entry_resolved,
    output logic                   lb_full,
    output lb_idx_t                lb_alloc_idx,
    // selected load, same cycle
    output logic                   issue_valid,
    output word_t                  issue_addr,
    output mem_size_e              issue_size,
    output logic                   issue_signed,
    output prf_idx_t               issue_dest_preg,
    output rob_idx_t               issue_rob_idx,
    output sq_count_t              issue_older_count
);

    load_state_e            state [lb_capacity];
    sq_count_t              older_count [lb_capacity];
    word_t                  load_addr [lb_capacity];
    mem_size_e              load_size [lb_capacity];
    logic [lb_capacity-1:0] load_signed;
    prf_idx_t               load_dest [lb_capacity];
    rob_idx_t               load_rob [lb_capacity];
    logic [lb_capacity-1:0] ready;
    lb_idx_t                issue_idx;
    logic                   resolve_take;

    // free list, lowest free slot wins
    always_comb begin
        lb_full      = 1'b1;
        lb_alloc_idx = '0;
        for (int j = lb_capacity - 1; j >= 0; j--) begin
            if (state[j] == free) begin
                lb_full      = 1'b0;
                lb_alloc_idx = lb_idx_t'(j);
            end
        end
    end

    assign resolve_take = lb_resolve_valid && state[lb_resolve_idx] == waiting_resolve;

    //////////////////////////////////////////////////////////////////////
    // readiness against older stores
    //////////////////////////////////////////////////////////////////////

    // older stores are the first older_count entries from head
    // unresolved or partial overlap blocks the load
    always_comb begin
        sq_idx_t st;
        for (int j = 0; j < lb_capacity; j++) begin
            ready[j] = (state[j] == resolved);
            for (int k = 0; k < sq_capacity; k++) begin
                st = sq_head + sq_idx_t'(k);
                if (k < older_count[j]) begin
                    if (!entry_resolved[st]) begin
                        ready[j] = 1'b0;
                    end else if (overlaps(entry_addr[st], entry_size[st],
                                          load_addr[j], load_size[j]) &&
                                 !covers(entry_addr[st], entry_size[st],
                                         load_addr[j], load_size[j])) begin
                        ready[j] = 1'b0;
                    end
                end
            end
        end
    end

    // lowest ready index
    always_comb begin
        issue_valid = |ready;
        issue_idx   = '0;
        for (int j = lb_capacity - 1; j >= 0; j--) begin
            if (ready[j]) begin
                issue_idx = lb_idx_t'(j);
            end
        end
    end

    assign issue_addr        = load_addr[issue_idx];
    assign issue_size        = load_size[issue_idx];
    assign issue_signed      = load_signed[issue_idx];
    assign issue_dest_preg   = load_dest[issue_idx];
    assign issue_rob_idx     = load_rob[issue_idx];
    assign issue_older_count = older_count[issue_idx];

    //////////////////////////////////////////////////////////////////////
    // entry state
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            for (int j = 0; j < lb_capacity; j++) begin
                state[j]       <= free;
                older_count[j] <= '0;
            end
        end else begin
            // each retirement removes one older store
            for (int j = 0; j < lb_capacity; j++) begin
                if (sq_retire && older_count[j] != '0) begin
                    older_count[j] <= older_count[j] - 1'b1;
                end
            end
            if (issue_valid) begin
                state[issue_idx] <= free;
            end
            // snapshot of the store count, less the store leaving now
            if (lb_alloc) begin
                state[lb_alloc_idx]       <= waiting_resolve;
                older_count[lb_alloc_idx] <= sq_retire ? sq_count - 1'b1 : sq_count;
            end
            if (resolve_take) begin
                state[lb_resolve_idx] <= resolved;
            end
        end
    end

    always_ff @(posedge clock) begin
        if (resolve_take) begin
            load_addr[lb_resolve_idx]   <= lb_base + lb_offset;
            load_size[lb_resolve_idx]   <= lb_size;
            load_signed[lb_resolve_idx] <= lb_signed;
            load_dest[lb_resolve_idx]   <= lb_dest_preg;
            load_rob[lb_resolve_idx]    <= lb_rob_idx;
        end
    end

    a_alloc_room: assert property (@(posedge clock) disable iff (reset)
        lb_alloc |-> !lb_full);

    a_resolve_waiting: assert property (@(posedge clock) disable iff (reset)
        lb_resolve_valid |-> state[lb_resolve_idx] == waiting_resolve);

    // a load never counts more older stores than the queue holds
    a_count_bound: assert property (@(posedge clock) disable iff (reset)
        issue_valid |-> issue_older_count <= sq_count);

endmodule

/* store_queue/store_forward.sv */
`timescale 1ns/10ps

module store_forward import lsq_pkg::*; (
    input  logic      clock,
    input  logic      reset,
    // selected load
    input  logic      issue_valid,
    input  word_t     issue_addr,
    input  mem_size_e issue_size,
    input  logic      issue_signed,
    input  prf_idx_t  issue_dest_preg,
    input  rob_idx_t  issue_rob_idx,
    input  sq_count_t issue_older_count,
    // store queue view
    input  sq_idx_t   sq_head,
    input  word_t     entry_addr [sq_capacity],
    input  word_t     entry_data [sq_capacity],
    input  mem_size_e entry_size [sq_capacity],
    // forwarded result
    output logic      forward_valid,
    output word_t     forward_value,
    output prf_idx_t  forward_dest_preg,
    output rob_idx_t  forward_rob_idx,
    // miss goes to the data cache
    output logic      load_cache_valid,
    output word_t     load_cache_addr,
    output mem_size_e load_cache_size,
    output logic      load_cache_signed,
    output prf_idx_t  load_cache_dest_preg,
    output rob_idx_t  load_cache_rob_idx
);

    logic       hit;
    sq_idx_t    hit_idx;
    logic [1:0] byte_shift;
    word_t      shifted;
    word_t      extended;
    prf_idx_t   dest_q;
    rob_idx_t   rob_q;

    //////////////////////////////////////////////////////////////////////
    // search
    //////////////////////////////////////////////////////////////////////

    // walk oldest to youngest, last cover wins, so the youngest one sticks
    always_comb begin
        sq_idx_t st;
        hit     = 1'b0;
        hit_idx = sq_head;
        for (int k = 0; k < sq_capacity; k++) begin
            st = sq_head + sq_idx_t'(k);
            if (k < issue_older_count &&
                covers(entry_addr[st], entry_size[st], issue_addr, issue_size)) begin
                hit     = 1'b1;
                hit_idx = st;
            end
        end
    end

    // covered load sits at most 3 bytes into the store
    assign byte_shift = issue_addr[1:0] - entry_addr[hit_idx][1:0];
    assign shifted    = entry_data[hit_idx] >> {byte_shift, 3'b000};

    // sign or zero extend to xlen
    always_comb begin
        case (issue_size)
            byte_access: extended = {{(xlen-8){issue_signed & shifted[7]}}, shifted[7:0]};
            half_access: extended = {{(xlen-16){issue_signed & shifted[15]}}, shifted[15:0]};
            default:     extended = shifted;
        endcase
    end

    //////////////////////////////////////////////////////////////////////
    // result registers
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            forward_valid    <= 1'b0;
            load_cache_valid <= 1'b0;
        end else begin
            forward_valid    <= issue_valid && hit;
            load_cache_valid <= issue_valid && !hit;
        end
    end

    always_ff @(posedge clock) begin
        if (issue_valid) begin
            forward_value     <= extended;
            load_cache_addr   <= issue_addr;
            load_cache_size   <= issue_size;
            load_cache_signed <= issue_signed;
            dest_q            <= issue_dest_preg;
            rob_q             <= issue_rob_idx;
        end
    end

    // tags shared by both result paths
    assign forward_dest_preg    = dest_q;
    assign forward_rob_idx      = rob_q;
    assign load_cache_dest_preg = dest_q;
    assign load_cache_rob_idx   = rob_q;

    a_one_result: assert property (@(posedge clock) disable iff (reset)
        !(forward_valid && load_cache_valid));

endmodule

/* store_queue/store_queue.sv */
`timescale 1ns/10ps

module store_queue import lsq_pkg::*; (
    input  logic                   clock,
    input  logic                   reset,
    // allocation, program order
    input  logic                   sq_alloc,
    // resolution, any order
    input  logic                   sq_resolve_valid,
    input  sq_idx_t                sq_resolve_idx,
    input  word_t                  sq_base,
    input  word_t                  sq_offset,
    input  word_t                  sq_data,
    input  mem_size_e              sq_size,
    input  rob_idx_t               sq_rob_idx,
    // rob commit of the head store
    input  logic                   sq_retire,
    output logic                   sq_full,
    output logic                   sq_head_resolved,
    output sq_idx_t                sq_tail,
    output sq_idx_t                sq_head,
    output sq_count_t              sq_count,
    // entry view for the load side
    output word_t                  entry_addr [sq_capacity],
    output word_t                  entry_data [sq_capacity],
    output mem_size_e              entry_size [sq_capacity],
    output logic [sq_capacity-1:0] entry_resolved,
    // head store to the data cache
    output logic                   store_cache_valid,
    output word_t                  store_cache_addr,
    output word_t                  store_cache_data,
    output mem_size_e              store_cache_size
);

    rob_idx_t               entry_rob [sq_capacity];
    logic [sq_capacity-1:0] entry_live;
    logic                   resolve_take;
    logic                   rob_clash;

    // pointer step, wraps at capacity
    function automatic sq_idx_t bump(sq_idx_t ptr);
        return (ptr == sq_idx_t'(sq_capacity - 1)) ? '0 : ptr + 1'b1;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // occupancy
    //////////////////////////////////////////////////////////////////////

    // live entries sit from head up to head + count
    always_comb begin
        for (int i = 0; i < sq_capacity; i++) begin
            entry_live[i] = sq_idx_t'(sq_idx_t'(i) - sq_head) < sq_count;
        end
    end

    assign sq_full          = (sq_count == sq_count_t'(sq_capacity));
    assign sq_head_resolved = entry_resolved[sq_head];

    // ignore resolves of dead or already resolved slots
    assign resolve_take = sq_resolve_valid && entry_live[sq_resolve_idx] &&
                          !entry_resolved[sq_resolve_idx];

    // same rob tag already resolved somewhere in the queue
    always_comb begin
        rob_clash = 1'b0;
        for (int i = 0; i < sq_capacity; i++) begin
            if (entry_live[i] && entry_resolved[i] && entry_rob[i] == sq_rob_idx) begin
                rob_clash = 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // pointers and resolved bits
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clock) begin
        if (reset) begin
            sq_head        <= '0;
            sq_tail        <= '0;
            sq_count       <= '0;
            entry_resolved <= '0;
        end else begin
            // new slot was cleared when it last retired
            if (sq_alloc) begin
                sq_tail <= bump(sq_tail);
            end
            if (resolve_take) begin
                entry_resolved[sq_resolve_idx] <= 1'b1;
            end
            if (sq_retire) begin
                entry_resolved[sq_head] <= 1'b0;
                sq_head                 <= bump(sq_head);
            end
            // alloc and retire together leave the count alone
            case ({sq_alloc, sq_retire})
                2'b10:   sq_count <= sq_count + 1'b1;
                2'b01:   sq_count <= sq_count - 1'b1;
                default: sq_count <= sq_count;
            endcase
        end
    end

    // payload, written on resolve
    always_ff @(posedge clock) begin
        if (resolve_take) begin
            entry_addr[sq_resolve_idx] <= sq_base + sq_offset;
            entry_data[sq_resolve_idx] <= sq_data;
            entry_size[sq_resolve_idx] <= sq_size;
            entry_rob[sq_resolve_idx]  <= sq_rob_idx;
        end
    end

    // head goes out in the retire cycle
    assign store_cache_valid = sq_retire;
    assign store_cache_addr  = entry_addr[sq_head];
    assign store_cache_data  = entry_data[sq_head];
    assign store_cache_size  = entry_size[sq_head];

    a_alloc_room: assert property (@(posedge clock) disable iff (reset)
        sq_alloc |-> !sq_full);

    a_retire_resolved: assert property (@(posedge clock) disable iff (reset)
        sq_retire |-> sq_head_resolved);

    // one rob slot never holds two stores in flight
    a_rob_unique: assert property (@(posedge clock) disable iff (reset)
        resolve_take |-> !rob_clash);

endmodule

/* common/lsq_pkg.sv */
package lsq_pkg;

    // datapath width
    localparam int xlen          = 32;

    // store queue geometry
    localparam int sq_capacity   = 8;
    localparam int sq_idx_bits   = 3;
    // store count spans 0 through sq_capacity
    localparam int sq_count_bits = 4;

    // load buffer geometry
    localparam int lb_capacity   = 4;
    localparam int lb_idx_bits   = 2;

    // tags handed back to the core
    localparam int prf_idx_bits  = 6;
    localparam int rob_idx_bits  = 5;

    typedef logic [xlen-1:0]          word_t;
    typedef logic [sq_idx_bits-1:0]   sq_idx_t;
    typedef logic [lb_idx_bits-1:0]   lb_idx_t;
    typedef logic [sq_count_bits-1:0] sq_count_t;
    typedef logic [prf_idx_bits-1:0]  prf_idx_t;
    typedef logic [rob_idx_bits-1:0]  rob_idx_t;

    // log2 of the byte count
    typedef enum logic [1:0] {
        byte_access = 2'd0,
        half_access = 2'd1,
        word_access = 2'd2
    } mem_size_e;

    // load entry life cycle
    typedef enum logic [1:0] {
        free            = 2'd0,
        waiting_resolve = 2'd1,
        resolved        = 2'd2
    } load_state_e;

    // one past the last byte
    // extra top bit keeps accesses near the top of memory from wrapping
    function automatic logic [xlen:0] access_end(word_t addr, mem_size_e size);
        logic [xlen:0] bytes;
        bytes = {{xlen{1'b0}}, 1'b1} << size;
        return {1'b0, addr} + bytes;
    endfunction

    // every load byte lies inside the store
    function automatic logic covers(word_t st_addr, mem_size_e st_size,
                                    word_t ld_addr, mem_size_e ld_size);
        return (ld_addr >= st_addr) &&
               (access_end(ld_addr, ld_size) <= access_end(st_addr, st_size));
    endfunction

    // at least one byte shared
    function automatic logic overlaps(word_t st_addr, mem_size_e st_size,
                                      word_t ld_addr, mem_size_e ld_size);
        return ({1'b0, ld_addr} < access_end(st_addr, st_size)) &&
               ({1'b0, st_addr} < access_end(ld_addr, ld_size));
    endfunction

endpackage
